// ==== logic/pcie_req_pkg.sv ====
// ********************
// Single-beat completer requests only, one dword of data per beat
// Header fields are pre-decoded, no raw TLP layout
// ********************
package pcie_req_pkg;

    // Request kinds that the host can send on CQ
    typedef enum logic [1:0] {
        REQ_MEM_READ  = 2'd0,
        REQ_MEM_WRITE = 2'd1,
        REQ_IO_READ   = 2'd2,
        REQ_MSG       = 2'd3
    } req_type_e;

    // Completion status carried on CC
    typedef enum logic {
        CPL_SC = 1'b0, // Successful completion
        CPL_UR = 1'b1  // Unsupported request, data is zero
    } cpl_status_e;

    // Dword address inside a BAR
    localparam int ADDR_W = 8;

    // Tag and requester ID are echoed back unchanged
    localparam int TAG_W    = 8;
    localparam int REQ_ID_W = 16;

    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8; // One enable per byte

    // Wide enough for BAR0 to BAR5
    localparam int BAR_W = 3;

endpackage

// ==== logic/core_regs_pkg.sv ====
// ********************
// BAR0 map is dword addressed, unmapped addresses read zero
// BAR2 aperture wraps at RAM_DEPTH words
// ********************
package core_regs_pkg;

    // BAR0 dword addresses
    typedef enum logic [7:0] {
        REG_ID       = 8'd0, // Read only identification word
        REG_SCRATCH  = 8'd1, // Free read/write register
        REG_LED      = 8'd2, // Bits 7:0 green, bits 15:8 red
        REG_WR_COUNT = 8'd3  // Number of BAR2 writes, read only
    } reg_addr_e;

    // Value returned by REG_ID
    localparam logic [31:0] CORE_ID_VALUE = 32'h4550_0100;

    // BAR2 word memory
    localparam int RAM_DEPTH  = 256;
    localparam int RAM_ADDR_W = 8;

endpackage

// ==== logic/cq_request_decoder.sv ====
// ********************
// Only BAR0 and BAR2 are served, other reads complete as UR
// Messages and stray writes are dropped without a trace
// ********************
`timescale 1ns/1ns

module cq_request_decoder (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 cq_valid,
    output logic                                 cq_ready,
    input  pcie_req_pkg::req_type_e              cq_type,
    input  logic [pcie_req_pkg::BAR_W-1:0]       cq_bar,
    input  logic [pcie_req_pkg::ADDR_W-1:0]      cq_addr,
    input  logic [pcie_req_pkg::TAG_W-1:0]       cq_tag,
    input  logic [pcie_req_pkg::REQ_ID_W-1:0]    cq_requester_id,
    input  logic [pcie_req_pkg::BE_W-1:0]        cq_byte_en,
    input  logic [pcie_req_pkg::DATA_W-1:0]      cq_data,
    input  logic                                 pipe_advance,
    output logic                                 req_valid,
    output logic                                 req_write,
    output logic                                 req_read,
    output logic                                 req_ur,
    output logic                                 req_bar2,
    output logic [pcie_req_pkg::ADDR_W-1:0]      req_addr,
    output logic [pcie_req_pkg::BE_W-1:0]        req_byte_en,
    output logic [pcie_req_pkg::DATA_W-1:0]      req_data,
    output logic [pcie_req_pkg::TAG_W-1:0]       req_tag,
    output logic [pcie_req_pkg::REQ_ID_W-1:0]    req_requester_id
);
    import pcie_req_pkg::*;

    logic take_beat;
    logic bar_hit;  // BAR0 or BAR2
    logic is_read;
    logic is_write;
    logic is_ur;

    // The stage can take a new beat whenever the whole pipeline moves
    assign cq_ready  = pipe_advance;
    assign take_beat = cq_valid && cq_ready;

    assign bar_hit  = (cq_bar == BAR_W'(0)) || (cq_bar == BAR_W'(2));
    assign is_read  = (cq_type == REQ_MEM_READ) && bar_hit;
    assign is_write = (cq_type == REQ_MEM_WRITE) && bar_hit;

    // I/O reads are never supported, memory reads only on the two BARs
    assign is_ur = (cq_type == REQ_IO_READ) || ((cq_type == REQ_MEM_READ) && !bar_hit);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
            req_write <= 1'b0;
            req_read  <= 1'b0;
            req_ur    <= 1'b0;
        end else if (pipe_advance) begin
            // An empty cycle or a dropped beat leaves the stage empty
            req_valid <= take_beat && (is_read || is_write || is_ur);
            req_write <= take_beat && is_write;
            req_read  <= take_beat && is_read;
            req_ur    <= take_beat && is_ur;
        end
    end

    always_ff @(posedge clk) begin
        if (take_beat) begin
            req_bar2         <= (cq_bar == BAR_W'(2));
            req_addr         <= cq_addr;
            req_byte_en      <= cq_byte_en;
            req_data         <= cq_data;
            req_tag          <= cq_tag;
            req_requester_id <= cq_requester_id;
        end
    end

endmodule

// ==== logic/bar0_register_file.sv ====
// ********************
// REG_ID and REG_WR_COUNT ignore writes, byte enables apply elsewhere
// Read data is valid one cycle after the request stage advances
// ********************
`timescale 1ns/1ns

module bar0_register_file (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               req_valid,
    input  logic                               req_write,
    input  logic                               req_read,
    input  logic                               req_bar2,
    input  logic                               pipe_advance,
    input  logic [pcie_req_pkg::ADDR_W-1:0]    req_addr,
    input  logic [pcie_req_pkg::BE_W-1:0]      req_byte_en,
    input  logic [pcie_req_pkg::DATA_W-1:0]    req_data,
    output logic [pcie_req_pkg::DATA_W-1:0]    bar0_rd_data,
    output logic [7:0]                         led_red,
    output logic [7:0]                         led_green
);
    import pcie_req_pkg::*;
    import core_regs_pkg::*;

    logic              bar0_wr;
    logic              bar0_rd;
    logic              bar2_wr;
    logic [DATA_W-1:0] scratch_reg;
    logic [DATA_W-1:0] led_reg;
    logic [DATA_W-1:0] wr_count;
    logic [DATA_W-1:0] rd_mux;

    // Everything happens on the edge where the request stage hands over
    assign bar0_wr = req_valid && pipe_advance && req_write && !req_bar2;
    assign bar0_rd = req_valid && pipe_advance && req_read && !req_bar2;
    assign bar2_wr = req_valid && pipe_advance && req_write && req_bar2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scratch_reg <= '0;
            led_reg     <= '0;   // LEDs dark after reset
            wr_count    <= '0;
        end else begin
            if (bar0_wr && (req_addr == REG_SCRATCH)) begin
                for (int i = 0; i < BE_W; i++) begin
                    if (req_byte_en[i]) scratch_reg[8*i +: 8] <= req_data[8*i +: 8];
                end
            end
            if (bar0_wr && (req_addr == REG_LED)) begin
                for (int i = 0; i < BE_W; i++) begin
                    if (req_byte_en[i]) led_reg[8*i +: 8] <= req_data[8*i +: 8];
                end
            end
            if (bar2_wr) wr_count <= wr_count + 32'd1; // Wraps at 32 bits
        end
    end

    always_comb begin
        case (req_addr)
            REG_ID:       rd_mux = CORE_ID_VALUE;
            REG_SCRATCH:  rd_mux = scratch_reg;
            REG_LED:      rd_mux = led_reg;
            REG_WR_COUNT: rd_mux = wr_count;
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (bar0_rd) bar0_rd_data <= rd_mux;
    end

    assign led_green = led_reg[7:0];
    assign led_red   = led_reg[15:8];

endmodule

// ==== logic/bar2_ram.sv ====
// ********************
// Contents are not reset and read undefined until written
// Upper address bits beyond RAM_ADDR_W are ignored
// ********************
`timescale 1ns/1ns

module bar2_ram (
    input  logic                               clk,
    input  logic                               req_valid,
    input  logic                               req_write,
    input  logic                               req_read,
    input  logic                               req_bar2,
    input  logic                               pipe_advance,
    input  logic [pcie_req_pkg::ADDR_W-1:0]    req_addr,
    input  logic [pcie_req_pkg::BE_W-1:0]      req_byte_en,
    input  logic [pcie_req_pkg::DATA_W-1:0]    req_data,
    output logic [pcie_req_pkg::DATA_W-1:0]    bar2_rd_data
);
    import pcie_req_pkg::*;
    import core_regs_pkg::*;

    logic [DATA_W-1:0]     mem [RAM_DEPTH];
    logic [RAM_ADDR_W-1:0] ram_addr;
    logic                  ram_wr;
    logic                  ram_rd;

    assign ram_addr = req_addr[RAM_ADDR_W-1:0];

    // Only requests aimed at BAR2 touch the memory
    assign ram_wr = req_valid && pipe_advance && req_write && req_bar2;
    assign ram_rd = req_valid && pipe_advance && req_read && req_bar2;

    always_ff @(posedge clk) begin
        if (ram_wr) begin
            for (int i = 0; i < BE_W; i++) begin
                if (req_byte_en[i]) mem[ram_addr][8*i +: 8] <= req_data[8*i +: 8];
            end
        end
    end

    // Registered read port, lines up with the completion stage
    always_ff @(posedge clk) begin
        if (ram_rd) bar2_rd_data <= mem[ram_addr];
    end

endmodule

// ==== logic/cc_completion_builder.sv ====
// ********************
// One completion beat per read, held until cc_ready
// pipe_advance stalls the decoder and both BAR targets
// ********************
`timescale 1ns/1ns

module cc_completion_builder (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 req_valid,
    input  logic                                 req_read,
    input  logic                                 req_ur,
    input  logic                                 req_bar2,
    input  logic [pcie_req_pkg::TAG_W-1:0]       req_tag,
    input  logic [pcie_req_pkg::REQ_ID_W-1:0]    req_requester_id,
    input  logic [pcie_req_pkg::DATA_W-1:0]      bar0_rd_data,
    input  logic [pcie_req_pkg::DATA_W-1:0]      bar2_rd_data,
    output logic                                 pipe_advance,
    output logic                                 cc_valid,
    input  logic                                 cc_ready,
    output logic [pcie_req_pkg::TAG_W-1:0]       cc_tag,
    output logic [pcie_req_pkg::REQ_ID_W-1:0]    cc_requester_id,
    output logic [pcie_req_pkg::DATA_W-1:0]      cc_data,
    output pcie_req_pkg::cpl_status_e            cc_status
);
    import pcie_req_pkg::*;

    logic sel_bar2; // Which target holds the data for this beat

    // The pipeline moves when the output slot is free or drains now
    assign pipe_advance = !cc_valid || cc_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cc_valid <= 1'b0;
        end else if (pipe_advance) begin
            cc_valid <= req_valid && (req_read || req_ur); // Writes need no completion
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_advance) begin
            cc_tag          <= req_tag;
            cc_requester_id <= req_requester_id;
            cc_status       <= req_ur ? CPL_UR : CPL_SC;
            sel_bar2        <= req_bar2;
        end
    end

    // The targets registered their read data on the same edge as this stage
    always_comb begin
        if (cc_status == CPL_UR) begin
            cc_data = '0;
        end else if (sel_bar2) begin
            cc_data = bar2_rd_data;
        end else begin
            cc_data = bar0_rd_data;
        end
    end

endmodule

// ==== logic/fpga_core.sv ====
// ********************
// Completer path only, one clock, synchronous active-low reset
// Read latency is two cycles from CQ accept to CC valid
// ********************
`timescale 1ns/1ns

module fpga_core (
    input  logic                                 clk,
    input  logic                                 rst_n,

    input  logic                                 cq_valid,
    output logic                                 cq_ready,
    input  pcie_req_pkg::req_type_e              cq_type,
    input  logic [pcie_req_pkg::BAR_W-1:0]       cq_bar,
    input  logic [pcie_req_pkg::ADDR_W-1:0]      cq_addr,
    input  logic [pcie_req_pkg::TAG_W-1:0]       cq_tag,
    input  logic [pcie_req_pkg::REQ_ID_W-1:0]    cq_requester_id,
    input  logic [pcie_req_pkg::BE_W-1:0]        cq_byte_en,
    input  logic [pcie_req_pkg::DATA_W-1:0]      cq_data,

    output logic                                 cc_valid,
    input  logic                                 cc_ready,
    output logic [pcie_req_pkg::TAG_W-1:0]       cc_tag,
    output logic [pcie_req_pkg::REQ_ID_W-1:0]    cc_requester_id,
    output pcie_req_pkg::cpl_status_e            cc_status,
    output logic [pcie_req_pkg::DATA_W-1:0]      cc_data,

    output logic [7:0]                           led_red,
    output logic [7:0]                           led_green
);
    import pcie_req_pkg::*;

    // Request stage shared by both targets and the builder
    logic                req_valid;
    logic                req_write;
    logic                req_read;
    logic                req_ur;
    logic                req_bar2;
    logic [ADDR_W-1:0]   req_addr;
    logic [BE_W-1:0]     req_byte_en;
    logic [DATA_W-1:0]   req_data;
    logic [TAG_W-1:0]    req_tag;
    logic [REQ_ID_W-1:0] req_requester_id;

    logic                pipe_advance;  // Single stall signal for the pipeline
    logic [DATA_W-1:0]   bar0_rd_data;
    logic [DATA_W-1:0]   bar2_rd_data;

    cq_request_decoder u_decoder (
        .clk(clk), .rst_n(rst_n),
        .cq_valid(cq_valid), .cq_ready(cq_ready), .cq_type(cq_type), .cq_bar(cq_bar),
        .cq_addr(cq_addr), .cq_tag(cq_tag), .cq_requester_id(cq_requester_id),
        .cq_byte_en(cq_byte_en), .cq_data(cq_data),
        .pipe_advance(pipe_advance),
        .req_valid(req_valid), .req_write(req_write), .req_read(req_read),
        .req_ur(req_ur), .req_bar2(req_bar2),
        .req_addr(req_addr), .req_byte_en(req_byte_en), .req_data(req_data),
        .req_tag(req_tag), .req_requester_id(req_requester_id)
    );

    bar0_register_file u_bar0 (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_write(req_write), .req_read(req_read),
        .req_bar2(req_bar2), .pipe_advance(pipe_advance),
        .req_addr(req_addr), .req_byte_en(req_byte_en), .req_data(req_data),
        .bar0_rd_data(bar0_rd_data),
        .led_red(led_red), .led_green(led_green)
    );

    bar2_ram u_bar2 (
        .clk(clk),
        .req_valid(req_valid), .req_write(req_write), .req_read(req_read),
        .req_bar2(req_bar2), .pipe_advance(pipe_advance),
        .req_addr(req_addr), .req_byte_en(req_byte_en), .req_data(req_data),
        .bar2_rd_data(bar2_rd_data)
    );

    cc_completion_builder u_builder (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_read(req_read), .req_ur(req_ur), .req_bar2(req_bar2),
        .req_tag(req_tag), .req_requester_id(req_requester_id),
        .bar0_rd_data(bar0_rd_data), .bar2_rd_data(bar2_rd_data),
        .pipe_advance(pipe_advance),
        .cc_valid(cc_valid), .cc_ready(cc_ready), .cc_tag(cc_tag),
        .cc_requester_id(cc_requester_id), .cc_data(cc_data), .cc_status(cc_status)
    );

endmodule

// ==== testbench/tb_fpga_core.sv ====
// ********************
// Random requests from a fixed LFSR seed, checked against a BAR0/BAR2 model
// BAR2 data is only checked for words whose four bytes were all written
// ********************
`timescale 1ns/1ns

module tb_fpga_core;
    import pcie_req_pkg::*;
    import core_regs_pkg::*;

    localparam int NUM_REQ_LIMIT  = 2000;
    localparam int TIMEOUT_CYCLES = NUM_REQ_LIMIT * 8 + 200;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [REQ_ID_W-1:0] requester_id;
        cpl_status_e         status;
        logic [DATA_W-1:0]   data;
        logic                data_known;
    } exp_cpl_t;

    logic clk;
    logic rst_n;
    logic cq_valid;
    logic cq_ready;
    req_type_e cq_type;
    logic [BAR_W-1:0] cq_bar;
    logic [ADDR_W-1:0] cq_addr;
    logic [TAG_W-1:0] cq_tag;
    logic [REQ_ID_W-1:0] cq_requester_id;
    logic [BE_W-1:0] cq_byte_en;
    logic [DATA_W-1:0] cq_data;
    logic cc_valid;
    logic cc_ready;
    logic [TAG_W-1:0] cc_tag;
    logic [REQ_ID_W-1:0] cc_requester_id;
    cpl_status_e cc_status;
    logic [DATA_W-1:0] cc_data;
    logic [7:0] led_red;
    logic [7:0] led_green;

    // Reference model of both BARs
    logic [DATA_W-1:0] scratch_model;
    logic [DATA_W-1:0] led_model;
    logic [DATA_W-1:0] wr_count_model;
    logic [DATA_W-1:0] ram_model [256];
    logic [BE_W-1:0]   ram_bytes [256]; // Bytes written so far per word
    exp_cpl_t          exp_q [$];
    exp_cpl_t          head;

    logic [31:0]      lfsr_state;
    logic             ready_mode;   // Random back-pressure on CC when set
    logic [TAG_W-1:0] next_tag;
    int               cycles = 0;

    fpga_core u_dut (
        .clk(clk), .rst_n(rst_n),
        .cq_valid(cq_valid), .cq_ready(cq_ready), .cq_type(cq_type), .cq_bar(cq_bar),
        .cq_addr(cq_addr), .cq_tag(cq_tag), .cq_requester_id(cq_requester_id),
        .cq_byte_en(cq_byte_en), .cq_data(cq_data),
        .cc_valid(cc_valid), .cc_ready(cc_ready), .cc_tag(cc_tag),
        .cc_requester_id(cc_requester_id), .cc_status(cc_status), .cc_data(cc_data),
        .led_red(led_red), .led_green(led_green)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old_word, logic [31:0] new_word,
                                                logic [3:0] be);
        logic [31:0] res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) res[8*i +: 8] = new_word[8*i +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] bar0_value(logic [ADDR_W-1:0] addr);
        logic [31:0] v;
        case (addr)
            REG_ID:       v = CORE_ID_VALUE;
            REG_SCRATCH:  v = scratch_model;
            REG_LED:      v = led_model;
            REG_WR_COUNT: v = wr_count_model;
            default:      v = 32'h0;
        endcase
        return v;
    endfunction

    task automatic stop_run(string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_word(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
        if (exp !== act) stop_run($sformatf("CHECK FAILED at %0t ns: %s expected %h actual %h",
                                            $time, name, exp, act));
    endtask

    task automatic check_tag(string name, logic [TAG_W-1:0] exp, logic [TAG_W-1:0] act);
        if (exp !== act) stop_run($sformatf("CHECK FAILED at %0t ns: %s expected %h actual %h",
                                            $time, name, exp, act));
    endtask

    task automatic check_req_id(string name, logic [REQ_ID_W-1:0] exp,
                                logic [REQ_ID_W-1:0] act);
        if (exp !== act) stop_run($sformatf("CHECK FAILED at %0t ns: %s expected %h actual %h",
                                            $time, name, exp, act));
    endtask

    task automatic check_status(string name, cpl_status_e exp, cpl_status_e act);
        if (exp !== act) stop_run($sformatf("CHECK FAILED at %0t ns: %s expected %s actual %s",
                                            $time, name, exp.name(), act.name()));
    endtask

    task automatic check_led(string name, logic [7:0] exp, logic [7:0] act);
        if (exp !== act) stop_run($sformatf("CHECK FAILED at %0t ns: %s expected %h actual %h",
                                            $time, name, exp, act));
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) stop_run($sformatf("CHECK FAILED at %0t ns: %s expected %b actual %b",
                                            $time, name, exp, act));
    endtask

    task automatic set_ready();
        if (ready_mode) cc_ready = 1'(rand_bits(1));
        else cc_ready = 1'b1;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(negedge clk);
            set_ready();
            cq_valid = 1'b0;
        end
    endtask

    // Applies an accepted request to the model and queues its completion
    task automatic predict(req_type_e kind, logic [BAR_W-1:0] bar, logic [ADDR_W-1:0] addr,
                           logic [BE_W-1:0] be, logic [DATA_W-1:0] data,
                           logic [TAG_W-1:0] tag, logic [REQ_ID_W-1:0] rid);
        exp_cpl_t e;
        e.tag          = tag;
        e.requester_id = rid;
        e.status       = CPL_SC;
        e.data         = 32'h0;
        e.data_known   = 1'b1;
        if (kind == REQ_MEM_WRITE && bar == 3'd0) begin
            if (addr == REG_SCRATCH) scratch_model = merge_bytes(scratch_model, data, be);
            if (addr == REG_LED) led_model = merge_bytes(led_model, data, be);
        end else if (kind == REQ_MEM_WRITE && bar == 3'd2) begin
            ram_model[addr] = merge_bytes(ram_model[addr], data, be);
            ram_bytes[addr] = ram_bytes[addr] | be;
            wr_count_model  = wr_count_model + 32'd1;
        end else if (kind == REQ_MEM_READ && bar == 3'd0) begin
            e.data = bar0_value(addr);
            exp_q.push_back(e);
        end else if (kind == REQ_MEM_READ && bar == 3'd2) begin
            e.data       = ram_model[addr];
            e.data_known = (ram_bytes[addr] == 4'hF);
            exp_q.push_back(e);
        end else if (kind == REQ_IO_READ || kind == REQ_MEM_READ) begin
            e.status = CPL_UR; // Zero data expected
            exp_q.push_back(e);
        end
    endtask

    task automatic send_req(req_type_e kind, logic [BAR_W-1:0] bar, logic [ADDR_W-1:0] addr,
                            logic [BE_W-1:0] be, logic [DATA_W-1:0] data);
        @(negedge clk);
        set_ready();
        cq_valid        = 1'b1;
        cq_type         = kind;
        cq_bar          = bar;
        cq_addr         = addr;
        cq_byte_en      = be;
        cq_data         = data;
        cq_tag          = next_tag;
        cq_requester_id = 16'(rand_bits(16));
        @(posedge clk);
        while (!cq_ready) begin
            @(negedge clk);
            set_ready();
            @(posedge clk);
        end
        next_tag = next_tag + 8'd1;
        predict(kind, bar, addr, be, data, cq_tag, cq_requester_id);
    endtask

    task automatic send_random_req();
        req_type_e        kind;
        logic [BAR_W-1:0] bar;
        logic [ADDR_W-1:0] addr;
        kind = req_type_e'(2'(rand_bits(2)));
        bar  = rand_bits(1) != 0 ? (rand_bits(1) != 0 ? 3'd2 : 3'd0) : 3'(rand_bits(3));
        addr = (bar == 3'd0) ? 8'(rand_bits(3)) : 8'(rand_bits(5));
        send_req(kind, bar, addr, 4'(rand_bits(4)), rand_bits(32));
    endtask

    // A read taken at edge N sits in the request stage after N and is on CC after N+1
    task automatic check_read_latency();
        send_req(REQ_MEM_READ, 3'd0, REG_ID, 4'hF, 32'h0);
        @(negedge clk);
        cq_valid = 1'b0;
        check_flag("cc_valid", 1'b0, cc_valid);
        @(negedge clk);
        check_flag("cc_valid", 1'b1, cc_valid);
        @(negedge clk);
        check_flag("cc_valid", 1'b0, cc_valid); // Taken once, nothing behind it
    endtask

    // Completion checker, pops one expected beat per CC handshake
    always @(posedge clk) begin
        if (rst_n && cc_valid && cc_ready) begin
            if (exp_q.size() == 0) begin
                stop_run("A completion arrived while no read was outstanding");
            end else begin
                head = exp_q.pop_front();
                check_tag("cc_tag", head.tag, cc_tag);
                check_req_id("cc_requester_id", head.requester_id, cc_requester_id);
                check_status("cc_status", head.status, cc_status);
                if (head.data_known) check_word("cc_data", head.data, cc_data);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) stop_run("Timeout: the run did not end within the cycle limit");
    end

    initial begin
        lfsr_state      = 32'd91927;
        rst_n           = 1'b0;
        cq_valid        = 1'b0;
        cq_type         = REQ_MEM_READ;
        cq_bar          = '0;
        cq_addr         = '0;
        cq_tag          = '0;
        cq_requester_id = '0;
        cq_byte_en      = '0;
        cq_data         = '0;
        cc_ready        = 1'b1;
        ready_mode      = 1'b0;
        next_tag        = '0;
        scratch_model   = '0;
        led_model       = '0;
        wr_count_model  = '0;
        for (int a = 0; a < 256; a++) ram_bytes[a] = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        check_flag("cc_valid", 1'b0, cc_valid);
        check_flag("cq_ready", 1'b1, cq_ready); // Builder is empty after reset
        check_led("led_green", 8'h00, led_green);
        check_led("led_red", 8'h00, led_red);
        idle(1);
        check_read_latency();

        // BAR2 fill, partial overwrites, then read back
        for (int a = 0; a < 32; a++) send_req(REQ_MEM_WRITE, 3'd2, 8'(a), 4'hF, rand_bits(32));
        repeat (64) send_req(REQ_MEM_WRITE, 3'd2, 8'(rand_bits(5)), 4'(rand_bits(4)),
                             rand_bits(32));
        repeat (32) send_req(REQ_MEM_READ, 3'd2, 8'(rand_bits(5)), 4'hF, 32'h0);

        repeat (16) begin
            send_req(REQ_MEM_WRITE, 3'd0, REG_SCRATCH, 4'(rand_bits(4)), rand_bits(32));
            send_req(REQ_MEM_WRITE, 3'd0, REG_LED, 4'(rand_bits(4)), rand_bits(32));
            idle(2);
            check_led("led_green", led_model[7:0], led_green);
            check_led("led_red", led_model[15:8], led_red);
            send_req(REQ_MEM_WRITE, 3'd0, REG_ID, 4'hF, rand_bits(32));
            send_req(REQ_MEM_WRITE, 3'd0, REG_WR_COUNT, 4'hF, rand_bits(32));
            for (int r = 0; r < 4; r++) send_req(REQ_MEM_READ, 3'd0, 8'(r), 4'hF, 32'h0);
        end

        ready_mode = 1'b1;
        repeat (1500) begin
            idle(int'(rand_bits(1)));
            send_random_req();
        end

        ready_mode = 1'b0;
        idle(8);
        check_led("led_green", led_model[7:0], led_green);
        check_led("led_red", led_model[15:8], led_red);
        if (exp_q.size() != 0) begin
            stop_run($sformatf("%0d expected completions never arrived", exp_q.size()));
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// ==== project.f ====
logic/pcie_req_pkg.sv
logic/core_regs_pkg.sv
logic/cq_request_decoder.sv
logic/bar0_register_file.sv
logic/bar2_ram.sv
logic/cc_completion_builder.sv
logic/fpga_core.sv
testbench/tb_fpga_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the fpga_core testbench with Verilator and runs it
# Exits non-zero when the build fails or the log reports an error

cd "$(dirname "$0")" || exit 1

TOP=tb_fpga_core
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --top-module "$TOP" -Mdir "$OBJ_DIR" -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ ! -f "$LOG" ]; then
    echo "Simulation log is missing"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation PASSED"
exit 0
